// File: Makefile
# Verilator build and run for the SDIO data path controller
# Override any variable on the command line, e.g. make LOG=run2.log

VERILATOR ?= verilator
TOP       ?= tb_sdio_data
RTL_TOP   ?= sdio_data_control
FILELIST  ?= sdio_data.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RTL_SRCS  ?= logic/sdio_data_pkg.sv logic/data_xfer_seq.sv logic/func_port_router.sv \
             logic/sdio_data_control.sv
TB_SRCS   ?= testbench/sdio_data_checker.sv testbench/tb_sdio_data.sv

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/data_xfer_seq.sv
// Transfer sequencer of the SDIO data path
// Walks IDLE, CONFIG, ACTIVE and the per-block waits while i_activate is high,
// counting bytes and blocks and advancing the address

`timescale 1ns/1ps

module data_xfer_seq (
  input  logic                             clk,
  input  logic                             rst,

  input  logic                             i_activate,
  input  sdio_data_pkg::xfer_req_t         i_req,

  input  sdio_data_pkg::phy_up_t           i_phy,
  input  sdio_data_pkg::target_up_t        i_sel_up,

  output logic                             o_xfer_active,
  output logic                             o_host_rdy,

  output logic                             o_busy,
  output logic                             o_finished,
  output logic [sdio_data_pkg::CNT_W-1:0]  o_total_data_cnt,
  output logic [sdio_data_pkg::ADDR_W-1:0] o_address
);

  localparam int CNT_W = sdio_data_pkg::CNT_W;

  sdio_data_pkg::xfer_state_t state;

  // Byte count in ACTIVE, idle cycle count in READ_COOLDOWN
  logic [CNT_W-1:0] byte_cnt;
  logic [CNT_W-1:0] block_cnt;
  logic [CNT_W-1:0] total_blocks;
  logic             continuous;

  logic             below_total;
  logic             beat;
  logic             more_blocks;

  assign below_total = (byte_cnt < o_total_data_cnt);

  // One byte moved in either direction
  assign beat = (state == sdio_data_pkg::ACTIVE) && i_phy.hst_rdy && below_total &&
                (i_phy.wr_stb || i_sel_up.rd_stb);

  assign more_blocks = continuous || (block_cnt < total_blocks);

  assign o_busy = (state == sdio_data_pkg::ACTIVE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state            <= sdio_data_pkg::IDLE;
      byte_cnt         <= '0;
      block_cnt        <= '0;
      total_blocks     <= '0;
      continuous       <= 1'b0;
      o_xfer_active    <= 1'b0;
      o_host_rdy       <= 1'b0;
      o_finished       <= 1'b0;
      o_total_data_cnt <= '0;
      o_address        <= '0;
    end else begin
      case (state)
        sdio_data_pkg::IDLE: begin
          o_finished    <= 1'b0;
          o_xfer_active <= 1'b0;
          o_host_rdy    <= 1'b0;
          byte_cnt      <= '0;
          block_cnt     <= '0;
          o_address     <= i_req.address;
          // Zero blocks in block mode means run until activate falls
          continuous    <= i_req.block_mode && (i_req.count == '0);
          total_blocks  <= i_req.block_mode ? i_req.count : '0;
          if (i_activate) begin
            state <= sdio_data_pkg::CONFIG;
          end
        end

        sdio_data_pkg::CONFIG: begin
          byte_cnt      <= '0;
          o_xfer_active <= 1'b1;
          if (i_req.block_mode) begin
            o_total_data_cnt <= i_sel_up.block_size[CNT_W-1:0];
            if (!continuous) begin
              block_cnt <= block_cnt + 1'b1;
            end
          end else if (i_req.count == '0) begin
            o_total_data_cnt <= CNT_W'(sdio_data_pkg::BYTE_MODE_DEFAULT_CNT);
          end else begin
            o_total_data_cnt <= i_req.count;
          end
          state <= sdio_data_pkg::ACTIVE;
        end

        sdio_data_pkg::ACTIVE: begin
          // Nothing moves while the PHY holds off
          if (i_phy.hst_rdy) begin
            if (below_total) begin
              o_host_rdy <= 1'b1;
              if (beat) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (i_req.inc_addr) begin
                  o_address <= o_address + 1'b1;
                end
              end
            end else begin
              o_host_rdy <= 1'b0;
              if (!i_req.block_mode) begin
                state <= sdio_data_pkg::FINISHED;
              end else if (i_req.write) begin
                state <= sdio_data_pkg::WAIT_FOR_PHY;
              end else begin
                byte_cnt <= '0;
                state    <= sdio_data_pkg::READ_COOLDOWN;
              end
            end
          end
        end

        sdio_data_pkg::WAIT_FOR_PHY: begin
          // PHY has sent the block and its CRC status
          if (i_phy.finished) begin
            o_xfer_active <= 1'b0;
            state <= more_blocks ? sdio_data_pkg::CONFIG : sdio_data_pkg::FINISHED;
          end
        end

        sdio_data_pkg::READ_COOLDOWN: begin
          if (byte_cnt < CNT_W'(sdio_data_pkg::READ_COOLDOWN_CYCLES)) begin
            byte_cnt <= byte_cnt + 1'b1;
          end else begin
            o_xfer_active <= 1'b0;
            state <= more_blocks ? sdio_data_pkg::CONFIG : sdio_data_pkg::FINISHED;
          end
        end

        sdio_data_pkg::FINISHED: begin
          o_xfer_active <= 1'b0;
          o_finished    <= 1'b1;
        end

        default: begin
          state <= sdio_data_pkg::FINISHED;
        end
      endcase

      // Dropping activate ends a finished transfer or cancels a running one
      if (!i_activate) begin
        state         <= sdio_data_pkg::IDLE;
        o_xfer_active <= 1'b0;
        o_host_rdy    <= 1'b0;
        o_finished    <= 1'b0;
      end
    end
  end

  // Completion is only reported once the data phase has left ACTIVE
  a_finished_not_busy : assert property (
    @(posedge clk) disable iff (rst) !(o_finished && o_busy)
  );

  // Counted beats stay within the total for the block
  a_count_in_range : assert property (
    @(posedge clk) disable iff (rst)
    (state == sdio_data_pkg::ACTIVE) |-> (byte_cnt <= o_total_data_cnt)
  );

endmodule

// File: logic/func_port_router.sv
// Combinational router between the data PHY and the nine targets
// Write bytes and ready levels go to the selected target only, and the
// selected target's read path and record come back

`timescale 1ns/1ps

module func_port_router (
  input  sdio_data_pkg::xfer_req_t    i_req,
  input  logic                        i_xfer_active,
  input  logic                        i_host_rdy,
  input  sdio_data_pkg::phy_up_t      i_phy,
  input  sdio_data_pkg::target_up_t   i_targets [sdio_data_pkg::NUM_TARGETS],
  output sdio_data_pkg::target_down_t o_targets [sdio_data_pkg::NUM_TARGETS],
  output sdio_data_pkg::phy_down_t    o_phy,
  output sdio_data_pkg::target_up_t   o_sel_up
);

  localparam int NUM_TARGETS = sdio_data_pkg::NUM_TARGETS;

  sdio_data_pkg::target_sel_t sel;
  logic [NUM_TARGETS-1:0]     activate_vec;

  // Memory space overrides the function number
  assign sel = i_req.mem_sel ? sdio_data_pkg::target_sel_t'(sdio_data_pkg::MEM_TARGET) :
                               {1'b0, i_req.func_sel};

  // PHY and sequencer toward the targets
  always_comb begin
    for (int i = 0; i < NUM_TARGETS; i++) begin
      o_targets[i] = '0;
      if (sdio_data_pkg::target_sel_t'(i) == sel) begin
        o_targets[i].wr_stb   = i_phy.wr_stb;
        o_targets[i].wr_data  = i_phy.wr_data;
        o_targets[i].hst_rdy  = i_host_rdy;
        o_targets[i].activate = i_xfer_active;
      end
    end
  end

  // Selected target back toward the PHY and sequencer
  always_comb begin
    o_sel_up = i_targets[sel];

    o_phy.rd_stb   = o_sel_up.rd_stb;
    o_phy.rd_data  = o_sel_up.rd_data;
    // Target may only send while the host side is ready too
    o_phy.com_rdy  = o_sel_up.com_rdy & i_host_rdy;
    o_phy.activate = i_xfer_active;
  end

  always_comb begin
    for (int i = 0; i < NUM_TARGETS; i++) begin
      activate_vec[i] = o_targets[i].activate;
    end
  end

  // Never two targets in a transfer at once
  always_comb begin
    a_single_activate : assert ($onehot0(activate_vec));
  end

endmodule

// File: logic/sdio_data_control.sv
// SDIO device data path controller, top level
// Connects the transfer sequencer and the target router to the PHY,
// the command layer and the nine byte-wide targets

`timescale 1ns/1ps

module sdio_data_control (
  input  logic                                 clk,
  input  logic                                 rst,

  // Command layer
  input  logic                                 i_activate,
  input  sdio_data_pkg::xfer_req_t             i_req,
  output logic                                 o_busy,
  output logic                                 o_finished,
  output logic [sdio_data_pkg::CNT_W-1:0]      o_total_data_cnt,
  output logic [sdio_data_pkg::ADDR_W-1:0]     o_address,

  // Data line PHY
  input  sdio_data_pkg::phy_up_t               i_phy,
  output sdio_data_pkg::phy_down_t             o_phy,

  // CIA, functions 1 to 7 and memory
  input  sdio_data_pkg::target_up_t            i_targets [sdio_data_pkg::NUM_TARGETS],
  output sdio_data_pkg::target_down_t          o_targets [sdio_data_pkg::NUM_TARGETS]
);

  logic                      xfer_active;
  logic                      host_rdy;
  sdio_data_pkg::target_up_t sel_up;

  // Phase sequencing, counters and address
  data_xfer_seq u_seq (
    .clk              (clk),
    .rst              (rst),
    .i_activate       (i_activate),
    .i_req            (i_req),
    .i_phy            (i_phy),
    .i_sel_up         (sel_up),
    .o_xfer_active    (xfer_active),
    .o_host_rdy       (host_rdy),
    .o_busy           (o_busy),
    .o_finished       (o_finished),
    .o_total_data_cnt (o_total_data_cnt),
    .o_address        (o_address)
  );

  // Byte steering between the PHY and the selected target
  func_port_router u_router (
    .i_req         (i_req),
    .i_xfer_active (xfer_active),
    .i_host_rdy    (host_rdy),
    .i_phy         (i_phy),
    .i_targets     (i_targets),
    .o_targets     (o_targets),
    .o_phy         (o_phy),
    .o_sel_up      (sel_up)
  );

endmodule

// File: logic/sdio_data_pkg.sv
// Shared widths, constants, FSM states and bus records of the SDIO data path controller
// Every file refers to these by scoped name

package sdio_data_pkg;

  localparam int DATA_W                = 8;
  localparam int ADDR_W                = 18;
  localparam int CNT_W                 = 13;
  localparam int BLK_SIZE_W            = 16;
  localparam int NUM_TARGETS           = 9;
  // CIA is target 0, functions 1 to 7 keep their own numbers
  localparam int MEM_TARGET            = 8;
  localparam int BYTE_MODE_DEFAULT_CNT = 512;
  localparam int READ_COOLDOWN_CYCLES  = 400;

  typedef logic [3:0] target_sel_t;

  typedef enum logic [2:0] {
    IDLE,
    CONFIG,
    ACTIVE,
    WAIT_FOR_PHY,
    READ_COOLDOWN,
    FINISHED
  } xfer_state_t;

  // Transfer request from the command layer, held while activate is high
  typedef struct packed {
    logic              write;
    logic              block_mode;
    logic              inc_addr;
    logic              mem_sel;
    logic [2:0]        func_sel;
    logic [CNT_W-1:0]  count;
    logic [ADDR_W-1:0] address;
  } xfer_req_t;

  // Controller to one target
  typedef struct packed {
    logic              wr_stb;
    logic [DATA_W-1:0] wr_data;
    logic              hst_rdy;
    logic              activate;
  } target_down_t;

  // One target back to the controller
  typedef struct packed {
    logic                  rd_stb;
    logic [DATA_W-1:0]     rd_data;
    logic                  com_rdy;
    logic [BLK_SIZE_W-1:0] block_size;
  } target_up_t;

  typedef struct packed {
    logic              rd_stb;
    logic [DATA_W-1:0] rd_data;
    logic              com_rdy;
    logic              activate;
  } phy_down_t;

  typedef struct packed {
    logic              wr_stb;
    logic [DATA_W-1:0] wr_data;
    logic              hst_rdy;
    logic              finished;
  } phy_up_t;

endpackage

// File: sdio_data.f
logic/sdio_data_pkg.sv
logic/data_xfer_seq.sv
logic/func_port_router.sv
logic/sdio_data_control.sv
testbench/sdio_data_checker.sv
testbench/tb_sdio_data.sv

// File: testbench/sdio_data_checker.sv
// Watches the SDIO data controller ports and compares them with expected results
// Prints one line per finished test and keeps the error counts for the testbench

`timescale 1ns/1ps

module sdio_data_checker (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             i_activate,
  input  sdio_data_pkg::xfer_req_t         i_req,
  input  sdio_data_pkg::phy_up_t           i_phy,
  input  sdio_data_pkg::phy_down_t         i_phy_down,
  input  sdio_data_pkg::target_up_t        i_targets [sdio_data_pkg::NUM_TARGETS],
  input  sdio_data_pkg::target_down_t      i_targets_down [sdio_data_pkg::NUM_TARGETS],
  input  logic                             i_busy,
  input  logic                             i_finished,
  input  logic [sdio_data_pkg::CNT_W-1:0]  i_total_data_cnt,
  input  logic [sdio_data_pkg::ADDR_W-1:0] i_address,
  input  int                               i_test_num,
  input  int                               i_exp_cnt,
  input  int                               i_exp_blocks,
  input  int                               i_exp_addr,
  input  logic                             i_test_end,
  output int                               o_errors,
  output int                               o_failed_tests,
  output int                               o_tests
);

  localparam int NUM = sdio_data_pkg::NUM_TARGETS;

  int   test_errors = 0;
  int   beats = 0;
  int   blocks_done = 0;
  int   phy_fins = 0;
  int   gap = 0;
  int   sel;
  logic busy_d = 1'b0;
  logic finished_d = 1'b0;
  logic act_d = 1'b0;
  logic host_seen = 1'b0;

  initial begin
    o_errors       = 0;
    o_failed_tests = 0;
    o_tests        = 0;
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %s: expected 0x%0h, got 0x%0h (test %0d)", name, exp, act, i_test_num);
      o_errors++;
      test_errors++;
    end
  endtask

  always @(posedge clk) begin
    sel = i_req.mem_sel ? sdio_data_pkg::MEM_TARGET : int'(i_req.func_sel);
    if (!rst) begin
      // Write path and levels reach only the selected target
      for (int i = 0; i < NUM; i++) begin
        check_val("o_targets.wr_stb", (i == sel) ? 32'(i_phy.wr_stb) : 32'd0,
                  32'(i_targets_down[i].wr_stb));
        check_val("o_targets.wr_data", (i == sel) ? 32'(i_phy.wr_data) : 32'd0,
                  32'(i_targets_down[i].wr_data));
        if (i != sel || (!i_activate && !act_d)) begin
          check_val("o_targets.activate", 32'd0, 32'(i_targets_down[i].activate));
          check_val("o_targets.hst_rdy", 32'd0, 32'(i_targets_down[i].hst_rdy));
        end
      end

      // Read path back to the PHY
      check_val("o_phy.rd_stb", 32'(i_targets[sel].rd_stb), 32'(i_phy_down.rd_stb));
      check_val("o_phy.rd_data", 32'(i_targets[sel].rd_data), 32'(i_phy_down.rd_data));
      if (!i_busy) begin
        check_val("o_phy.com_rdy", 32'd0, 32'(i_phy_down.com_rdy));
        check_val("o_targets.hst_rdy", 32'd0, 32'(i_targets_down[sel].hst_rdy));
      end else begin
        // Data phase runs on the selected target
        check_val("o_phy.activate", 32'd1, 32'(i_phy_down.activate));
        check_val("o_targets.activate", 32'd1, 32'(i_targets_down[sel].activate));
        if (host_seen) begin
          check_val("o_phy.com_rdy", 32'(i_targets[sel].com_rdy), 32'(i_phy_down.com_rdy));
          check_val("o_targets.hst_rdy", 32'd1, 32'(i_targets_down[sel].hst_rdy));
        end
      end
      host_seen = i_busy && (host_seen || i_phy.hst_rdy);

      // Idle within two cycles of activate falling
      if (!i_activate && !act_d) begin
        check_val("o_busy", 32'd0, 32'(i_busy));
        check_val("o_finished", 32'd0, 32'(i_finished));
        check_val("o_phy.activate", 32'd0, 32'(i_phy_down.activate));
      end

      if (i_activate && !act_d) begin
        beats       = 0;
        blocks_done = 0;
        phy_fins    = 0;
        gap         = 0;
      end
      if (i_busy && i_phy.hst_rdy && (i_phy.wr_stb || i_targets[sel].rd_stb)) begin
        beats++;
      end
      if (i_phy.finished) begin
        phy_fins++;
      end

      // A block ended normally
      if (busy_d && !i_busy && i_activate) begin
        check_val("block beats", i_exp_cnt, beats);
        check_val("o_total_data_cnt", i_exp_cnt, 32'(i_total_data_cnt));
        blocks_done++;
        beats = 0;
      end

      if (!i_busy) begin
        gap++;
      end
      if (i_busy && !busy_d && blocks_done > 0 && !i_req.write && i_req.block_mode &&
          gap < sdio_data_pkg::READ_COOLDOWN_CYCLES) begin
        $display("Read block started only %0d idle cycles after the previous one (test %0d)",
                 gap, i_test_num);
        o_errors++;
        test_errors++;
      end
      if (i_busy) begin
        gap = 0;
      end

      if (i_finished && !finished_d) begin
        check_val("o_address", i_exp_addr, 32'(i_address));
        check_val("block count", i_exp_blocks, blocks_done);
        if (i_req.write && i_req.block_mode) begin
          check_val("i_phy.finished pulses", i_exp_blocks, phy_fins);
        end
      end

      if (i_test_end) begin
        o_tests++;
        if (test_errors == 0) begin
          $display("test %0d ok", i_test_num);
        end else begin
          $display("test %0d failed with %0d errors", i_test_num, test_errors);
          o_failed_tests++;
        end
        test_errors = 0;
      end
    end
    busy_d     = i_busy;
    finished_d = i_finished;
    act_d      = i_activate;
  end

endmodule

// File: testbench/tb_sdio_data.sv
// Testbench for the SDIO data path controller
// Runs a routing sweep, then a table of transfers against PHY and target models

`timescale 1ns/1ps

module tb_sdio_data;

  localparam int NUM       = sdio_data_pkg::NUM_TARGETS;
  localparam int NUM_TESTS = 7;

  typedef struct packed {
    sdio_data_pkg::xfer_req_t req;
    logic [15:0]              exp_cnt;
    logic [15:0]              exp_blocks;
    logic [17:0]              exp_addr;
    logic [15:0]              cancel_after;
  } test_entry_t;

  logic                                 clk = 1'b0;
  logic                                 rst;
  logic                                 activate;
  sdio_data_pkg::xfer_req_t             req;
  sdio_data_pkg::phy_up_t               phy_up = '0;
  sdio_data_pkg::phy_down_t             phy_down;
  sdio_data_pkg::target_up_t            tgt_up [NUM] = '{default: '0};
  sdio_data_pkg::target_down_t          tgt_down [NUM];
  logic                                 busy;
  logic                                 finished;
  logic [sdio_data_pkg::CNT_W-1:0]      total_cnt;
  logic [sdio_data_pkg::ADDR_W-1:0]     address;

  test_entry_t tests [NUM_TESTS];
  int          test_num;
  int          exp_cnt;
  int          exp_blocks;
  int          exp_addr;
  logic        test_end;
  logic        route_phase;
  int          errors;
  int          failed_tests;
  int          tests_run;
  logic [31:0] lfsr_state = 32'h5aea_b83a;
  int          sent = 0;
  int          fin_wait = 0;
  logic        busy_seen = 1'b0;
  int          cycle_cnt = 0;
  int          cycle_limit = 1000000;

  always #5 clk = ~clk;

  sdio_data_control uut (
    .clk (clk), .rst (rst), .i_activate (activate), .i_req (req),
    .o_busy (busy), .o_finished (finished), .o_total_data_cnt (total_cnt),
    .o_address (address), .i_phy (phy_up), .o_phy (phy_down),
    .i_targets (tgt_up), .o_targets (tgt_down)
  );

  sdio_data_checker u_checker (
    .clk (clk), .rst (rst), .i_activate (activate), .i_req (req), .i_phy (phy_up),
    .i_phy_down (phy_down), .i_targets (tgt_up), .i_targets_down (tgt_down),
    .i_busy (busy), .i_finished (finished), .i_total_data_cnt (total_cnt),
    .i_address (address), .i_test_num (test_num), .i_exp_cnt (exp_cnt),
    .i_exp_blocks (exp_blocks), .i_exp_addr (exp_addr), .i_test_end (test_end),
    .o_errors (errors), .o_failed_tests (failed_tests), .o_tests (tests_run)
  );

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic take_bit();
    lfsr_state = lfsr_next(lfsr_state);
    return lfsr_state[0];
  endfunction

  function automatic logic [7:0] take_byte();
    logic [7:0] b;
    for (int k = 0; k < 8; k++) begin
      b[k] = take_bit();
    end
    return b;
  endfunction

  function automatic int target_index(input sdio_data_pkg::xfer_req_t r);
    return r.mem_sel ? sdio_data_pkg::MEM_TARGET : int'(r.func_sel);
  endfunction

  // One byte strobe, from the PHY on writes or from the selected target on reads
  task automatic drive_strobe();
    if (req.write) begin
      phy_up.wr_stb  = 1'b1;
      phy_up.wr_data = take_byte();
    end else begin
      tgt_up[target_index(req)].rd_stb  = 1'b1;
      tgt_up[target_index(req)].rd_data = take_byte();
    end
  endtask

  // PHY and target models, block size of target i is 8 + 4*i
  always @(negedge clk) begin
    phy_up = '0;
    for (int i = 0; i < NUM; i++) begin
      tgt_up[i].rd_stb     = 1'b0;
      tgt_up[i].rd_data    = '0;
      tgt_up[i].com_rdy    = take_bit();
      tgt_up[i].block_size = 16'(8 + 4 * i);
    end
    if (rst) begin
      sent     = 0;
      fin_wait = 0;
    end else if (route_phase) begin
      phy_up.wr_stb  = 1'b1;
      phy_up.wr_data = take_byte();
    end else begin
      if (busy) begin
        phy_up.hst_rdy = take_bit() | take_bit();
        if (phy_up.hst_rdy && sent < exp_cnt && (take_bit() | take_bit())) begin
          sent++;
          drive_strobe();
        end else if (!phy_up.hst_rdy && take_bit() && take_bit()) begin
          // A strobe during a pause is not a beat
          drive_strobe();
        end
      end else begin
        sent           = 0;
        phy_up.hst_rdy = take_bit();
      end
      // Write block CRC status comes back a few cycles after the data
      if (busy_seen && !busy && req.write && req.block_mode && activate) begin
        fin_wait = 2 + int'(take_bit());
      end else if (fin_wait > 0) begin
        fin_wait--;
        phy_up.finished = (fin_wait == 0);
      end
    end
    busy_seen = busy;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles, a transfer never completed", cycle_cnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic add_test(input int idx, input logic wr, input logic blk, input logic inc,
                          input logic mem, input int fn, input int cnt, input int addr,
                          input int e_cnt, input int e_blocks, input int e_addr,
                          input int cancel);
    tests[idx].req.write       = wr;
    tests[idx].req.block_mode  = blk;
    tests[idx].req.inc_addr    = inc;
    tests[idx].req.mem_sel     = mem;
    tests[idx].req.func_sel    = 3'(fn);
    tests[idx].req.count       = 13'(cnt);
    tests[idx].req.address     = 18'(addr);
    tests[idx].exp_cnt         = 16'(e_cnt);
    tests[idx].exp_blocks      = 16'(e_blocks);
    tests[idx].exp_addr        = 18'(e_addr);
    tests[idx].cancel_after    = 16'(cancel);
  endtask

  task automatic end_test();
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
    test_num++;
  endtask

  task automatic run_test(input int t);
    exp_cnt    = int'(tests[t].exp_cnt);
    exp_blocks = int'(tests[t].exp_blocks);
    exp_addr   = int'(tests[t].exp_addr);
    req        = tests[t].req;
    activate   = 1'b1;
    if (tests[t].cancel_after == 16'd0) begin
      while (!finished) begin
        @(negedge clk);
      end
      repeat (2) @(negedge clk);
    end else begin
      repeat (int'(tests[t].cancel_after)) @(negedge clk);
    end
    activate = 1'b0;
    repeat (4) @(negedge clk);
    end_test();
  endtask

  initial begin
    rst         = 1'b1;
    activate    = 1'b0;
    req         = '0;
    route_phase = 1'b0;
    test_end    = 1'b0;
    test_num    = 0;
    exp_cnt     = 0;
    exp_blocks  = 0;
    exp_addr    = 0;

    //       idx wr blk inc mem fn cnt addr      e_cnt blks e_addr   cancel
    add_test(0, 0, 0, 1, 0, 1, 20, 'h00100,  20,  1, 'h00114, 0);
    add_test(1, 1, 0, 1, 0, 3, 0,  'h01000,  512, 1, 'h01200, 0);
    add_test(2, 1, 0, 0, 1, 0, 7,  'h2abcd,  7,   1, 'h2abcd, 0);
    add_test(3, 1, 1, 1, 0, 2, 3,  'h00040,  16,  3, 'h00070, 0);
    add_test(4, 0, 1, 1, 0, 5, 2,  'h3ff00,  28,  2, 'h3ff38, 0);
    add_test(5, 0, 1, 0, 0, 0, 1,  'h00009,  8,   1, 'h00009, 0);
    add_test(6, 1, 1, 1, 0, 7, 0,  'h00000,  36,  1, 'h00000, 300);

    cycle_limit = 2000;
    for (int t = 0; t < NUM_TESTS; t++) begin
      cycle_limit += int'(tests[t].exp_blocks) *
                     (int'(tests[t].exp_cnt) + sdio_data_pkg::READ_COOLDOWN_CYCLES + 20) +
                     int'(tests[t].cancel_after);
    end

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Write byte to each target in turn with no transfer running
    route_phase = 1'b1;
    for (int s = 0; s < NUM; s++) begin
      req.mem_sel  = (s == sdio_data_pkg::MEM_TARGET);
      req.func_sel = 3'(s);
      @(negedge clk);
    end
    route_phase = 1'b0;
    end_test();

    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end

    $display("%0d tests, %0d failed, %0d errors", tests_run, failed_tests, errors);
    if (errors == 0 && failed_tests == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
